// File: flist.f
fpu_op_pkg.sv
fpu_data_pkg.sv
operand_bypass.sv
fpu_op_decode.sv
fp_compare.sv
fpu_result_stage.sv
fpu_except.sv
fpu_unit.sv
tb_fpu_unit.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_fpu_unit \
  -Mdir obj_dir -o sim_fpu_unit > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_fpu_unit > sim.log 2>&1
cat sim.log

grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

// File: tb_fpu_unit.sv
// directed testbench for fpu_unit
// reference model, compare tasks and one task per test
`timescale 1ns/1ps

module tb_fpu_unit import fpu_op_pkg::*, fpu_data_pkg::*; ();

  localparam int TIMEOUT = 20;

  logic       clk;
  logic       rst;
  logic       en;
  op_t        op;
  bus_word_t  a;
  bus_word_t  b;
  fwd_t       fwd_a;
  fwd_t       fwd_b;
  bus_word_t  bus0;
  bus_word_t  bus1;
  fpcsr_t     fpcsr;
  logic       res_valid;
  bus_word_t  res_bus;
  cmp_flags_t flags;
  ret_t       ret;
  logic       ret_en;

  logic [31:0] rng;
  int          cyc;
  bus_word_t   exp_bus_q[$];
  cmp_flags_t  exp_flags_q[$];
  ret_t        exp_ret_q[$];
  int          issue_cyc_q[$];

  fpu_unit fpu_unit_inst (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic data_t rand_double();
    logic [31:0] hi;
    rng = xorshift(rng);
    hi  = rng;
    rng = xorshift(rng);
    return {hi, rng};
  endfunction

  function automatic bus_word_t make_word(input data_t d);
    return {^d, d};
  endfunction

  function automatic logic is_nan(input data_t d);
    return (d[62:52] == 11'h7ff) && (d[51:0] != 52'd0);
  endfunction

  function automatic logic is_snan(input data_t d);
    return is_nan(d) && (d[51] == 1'b0);
  endfunction

  function automatic logic is_sub(input data_t d);
    return (d[62:52] == 11'd0) && (d[51:0] != 52'd0);
  endfunction

  function automatic logic is_compare(input op_t o);
    return (o == OP_CMP_ORD) || (o == OP_CMP_UNORD);
  endfunction

  // monotonic key with both zeros on one value
  function automatic data_t order_key(input data_t d);
    if (d[62:0] == 63'd0)
      return 64'h8000_0000_0000_0000;
    if (d[63])
      return ~d;
    return d | 64'h8000_0000_0000_0000;
  endfunction

  function automatic data_t ref_data(input op_t o, input data_t x, input data_t y);
    case (o)
      OP_AND:  return x & y;
      OP_OR:   return x | y;
      OP_XOR:  return x ^ y;
      OP_ANDN: return x & ~y;
      default: return 64'd0;
    endcase
  endfunction

  function automatic cmp_flags_t ref_flags(input op_t o, input data_t x, input data_t y);
    cmp_flags_t f;
    f = '0;
    if (!is_compare(o))
      return f;
    if (is_nan(x) || is_nan(y))
      f[FLG_UNORD] = 1'b1;
    else if (order_key(x) == order_key(y))
      f[FLG_EQ] = 1'b1;
    else if (order_key(x) < order_key(y))
      f[FLG_LT] = 1'b1;
    else
      f[FLG_GT] = 1'b1;
    return f;
  endfunction

  function automatic ret_t ref_ret(input op_t o, input bus_word_t sa, input bus_word_t sb,
                                   input fpcsr_t csr);
    excpt_t e;
    logic   trap;
    e = '0;
    if ((^sa) || (^sb))
      return 4'b0001;
    if (is_compare(o)) begin
      if (o == OP_CMP_ORD)
        e[EXC_INV] = is_nan(sa[63:0]) || is_nan(sb[63:0]);
      else
        e[EXC_INV] = is_snan(sa[63:0]) || is_snan(sb[63:0]);
      e[EXC_DEN] = is_sub(sa[63:0]) || is_sub(sb[63:0]);
    end
    trap = (e[EXC_INV] && csr[CSR_INV_EN]) || (e[EXC_DEN] && csr[CSR_DEN_EN]);
    return {e, trap, 1'b0};
  endfunction

  function automatic bus_word_t select_src(input fwd_t s, input bus_word_t disp,
                                           input bus_word_t b0, input bus_word_t b1,
                                           input bus_word_t old);
    if (s == FWD_BUS0)
      return b0;
    if (s == FWD_BUS1)
      return b1;
    if (s == FWD_BUS0_OLD)
      return old;
    return disp;
  endfunction

  task automatic fail_run();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic fail_msg(input string msg);
    $display("%s", msg);
    fail_run();
  endtask

  task automatic check_bus(input string name, input bus_word_t got, input bus_word_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_flags(input string name, input cmp_flags_t got, input cmp_flags_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_ret(input string name, input ret_t got, input ret_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  // one falling edge where outputs are stable
  task automatic tick();
    int age;
    @(negedge clk);
    cyc++;
    if (res_valid !== ret_en)
      fail_msg("res_valid and ret_en did not rise and fall together");
    if (res_valid === 1'b1) begin
      if (exp_bus_q.size() == 0)
        fail_msg("result strobe seen with no operation in flight");
      age = cyc - issue_cyc_q.pop_front();
      if (age != 2)
        fail_msg($sformatf("result came %0d cycles after issue instead of 2", age));
      if ((^res_bus) !== 1'b0)
        fail_msg("res_bus carries odd parity");
      check_bus("res_bus", res_bus, exp_bus_q.pop_front());
      check_flags("flags", flags, exp_flags_q.pop_front());
      check_ret("ret", ret, exp_ret_q.pop_front());
    end else begin
      check_bus("res_bus", res_bus, '0);
      check_flags("flags", flags, '0);
      check_ret("ret", ret, '0);
    end
  endtask

  task automatic idle();
    tick();
    en = 1'b0;
  endtask

  task automatic issue(input op_t o, input bus_word_t wa, input bus_word_t wb,
                       input fwd_t fa, input fwd_t fb, input bus_word_t b0,
                       input bus_word_t b1);
    bus_word_t old;
    bus_word_t sa;
    bus_word_t sb;
    tick();
    // bus0 as sampled on the previous rising edge
    old   = bus0;
    en    = 1'b1;
    op    = o;
    a     = wa;
    b     = wb;
    fwd_a = fa;
    fwd_b = fb;
    bus0  = b0;
    bus1  = b1;
    sa = select_src(fa, wa, b0, b1, old);
    sb = select_src(fb, wb, b0, b1, old);
    exp_bus_q.push_back(make_word(ref_data(o, sa[63:0], sb[63:0])));
    exp_flags_q.push_back(ref_flags(o, sa[63:0], sb[63:0]));
    exp_ret_q.push_back(ref_ret(o, sa, sb, fpcsr));
    issue_cyc_q.push_back(cyc);
  endtask

  task automatic issue_plain(input op_t o, input data_t x, input data_t y);
    issue(o, make_word(x), make_word(y), FWD_NONE, FWD_NONE, bus0, bus1);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_bus_q.size() != 0) begin
      idle();
      waited++;
      if (waited > TIMEOUT)
        fail_msg("timed out waiting for res_valid");
    end
    repeat (2) idle();
  endtask

  task automatic set_csr(input fpcsr_t v);
    drain();
    fpcsr = v;
  endtask

  task automatic test_reset_idle();
    repeat (8) idle();
    if (res_valid !== 1'b0 || ret_en !== 1'b0)
      fail_msg("strobes not low after reset");
  endtask

  task automatic test_logic_ops();
    op_t ops[4];
    ops = '{OP_AND, OP_OR, OP_XOR, OP_ANDN};
    set_csr(32'h3);
    for (int i = 0; i < 16; i++)
      issue_plain(ops[i % 4], rand_double(), rand_double());
    drain();
  endtask

  task automatic test_compare_fixed();
    set_csr(32'h0);
    issue_plain(OP_CMP_ORD, 64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000);
    issue_plain(OP_CMP_ORD, 64'hbff0_0000_0000_0000, 64'h3ff0_0000_0000_0000);
    issue_plain(OP_CMP_UNORD, 64'h4000_0000_0000_0000, 64'h4000_0000_0000_0000);
    issue_plain(OP_CMP_ORD, 64'h4008_0000_0000_0000, 64'hc014_0000_0000_0000);
    issue_plain(OP_CMP_ORD, 64'hc000_0000_0000_0000, 64'hc008_0000_0000_0000);
    for (int i = 0; i < 8; i++)
      issue_plain(i[0] ? OP_CMP_UNORD : OP_CMP_ORD, rand_double(), rand_double());
    issue_plain(OP_CMP_ORD, 64'h0000_0000_0000_0001, 64'h3ff0_0000_0000_0000);
    set_csr(32'h2);
    issue_plain(OP_CMP_UNORD, 64'hbff0_0000_0000_0000, 64'h8000_0000_0000_0003);
    drain();
  endtask

  task automatic test_nan();
    for (int c = 0; c < 3; c++) begin
      set_csr(fpcsr_t'(c));
      issue_plain(OP_CMP_ORD, 64'h7ff8_0000_0000_0000, 64'h3ff0_0000_0000_0000);
      issue_plain(OP_CMP_UNORD, 64'h3ff0_0000_0000_0000, 64'h7ff8_0000_0000_0000);
      issue_plain(OP_CMP_UNORD, 64'h7ff0_0000_0000_0001, 64'h4000_0000_0000_0000);
      issue_plain(OP_CMP_ORD, 64'hfff0_0000_0000_0001, 64'h0000_0000_0000_0001);
      // denormal without invalid
      issue_plain(OP_CMP_UNORD, 64'h0000_0000_0000_0001, 64'h3ff0_0000_0000_0000);
    end
    drain();
  endtask

  task automatic test_forwarding();
    set_csr(32'h0);
    issue(OP_XOR, make_word(rand_double()), make_word(rand_double()), FWD_BUS0, FWD_BUS1,
          make_word(rand_double()), make_word(rand_double()));
    issue(OP_OR, make_word(rand_double()), make_word(rand_double()), FWD_BUS0_OLD,
          FWD_BUS0, make_word(rand_double()), bus1);
    issue(OP_CMP_ORD, make_word(rand_double()), make_word(rand_double()), FWD_BUS1,
          FWD_BUS0_OLD, bus0, make_word(rand_double()));
    issue(OP_ANDN, make_word(rand_double()), make_word(rand_double()), FWD_NONE,
          FWD_BUS0, make_word(rand_double()), bus1);
    drain();
  endtask

  task automatic test_parity();
    bus_word_t flip;
    flip = {1'b1, 64'd0};
    set_csr(32'h3);
    issue(OP_CMP_ORD, make_word(64'h7ff8_0000_0000_0000) ^ flip,
          make_word(64'h3ff0_0000_0000_0000), FWD_NONE, FWD_NONE, bus0, bus1);
    issue(OP_CMP_UNORD, make_word(64'h7ff0_0000_0000_0001), make_word(64'd0), FWD_NONE,
          FWD_BUS1, bus0, make_word(64'h4000_0000_0000_0000) ^ flip);
    issue_plain(OP_CMP_ORD, 64'h7ff8_0000_0000_0000, 64'h3ff0_0000_0000_0000);
    drain();
  endtask

  initial begin
    clk   = 1'b0;
    rst   = 1'b1;
    en    = 1'b0;
    op    = OP_AND;
    a     = '0;
    b     = '0;
    fwd_a = FWD_NONE;
    fwd_b = FWD_NONE;
    bus0  = '0;
    bus1  = '0;
    fpcsr = '0;
    rng   = 32'h39fe;
    cyc   = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_idle();
    test_logic_ops();
    test_compare_fixed();
    test_nan();
    test_forwarding();
    test_parity();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: fpu_unit.sv
// logic and compare issue port: bypass, decode, compare,
// result and exception stages
`timescale 1ns/1ps

module fpu_unit import fpu_op_pkg::*, fpu_data_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       en,
  input  op_t        op,
  input  bus_word_t  a,
  input  bus_word_t  b,
  input  fwd_t       fwd_a,
  input  fwd_t       fwd_b,
  input  bus_word_t  bus0,
  input  bus_word_t  bus1,
  input  fpcsr_t     fpcsr,
  output logic       res_valid,
  output bus_word_t  res_bus,
  output cmp_flags_t flags,
  output ret_t       ret,
  output logic       ret_en
);

  bus_word_t  opa;
  bus_word_t  opb;
  logic       byp_valid;
  op_t        op_q;
  logic       is_cmp;
  logic       ordered;
  logic       dec_valid;
  cmp_flags_t cmp_flags;
  excpt_t     raised;

  // stage 1
  operand_bypass bypass_inst (
    .clk(clk), .rst(rst), .en(en), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .a(a), .b(b), .bus0(bus0), .bus1(bus1),
    .opa(opa), .opb(opb), .valid(byp_valid)
  );

  fpu_op_decode decode_inst (
    .clk(clk), .rst(rst), .en(en), .op(op),
    .op_q(op_q), .is_cmp(is_cmp), .ordered(ordered), .valid(dec_valid)
  );

  fp_compare compare_inst (
    .opa(opa), .opb(opb), .is_cmp(is_cmp), .ordered(ordered),
    .flags(cmp_flags), .raised(raised)
  );

  // stage 2
  fpu_result_stage result_inst (
    .clk(clk), .rst(rst), .valid(dec_valid), .op_q(op_q), .is_cmp(is_cmp),
    .opa(opa), .opb(opb), .flags_in(cmp_flags),
    .res_valid(res_valid), .res_bus(res_bus), .flags(flags)
  );

  fpu_except except_inst (
    .clk(clk), .rst(rst), .valid(byp_valid), .opa(opa), .opb(opb),
    .raised(raised), .fpcsr(fpcsr), .ret(ret), .ret_en(ret_en)
  );

endmodule

// File: fpu_except.sv
// operand parity check, exception masking and completion code
`timescale 1ns/1ps

module fpu_except import fpu_op_pkg::*, fpu_data_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      valid,
  input  bus_word_t opa,
  input  bus_word_t opb,
  input  excpt_t    raised,
  input  fpcsr_t    fpcsr,
  output ret_t      ret,
  output logic      ret_en
);

  logic   perr;
  logic   trap;
  excpt_t trap_en;
  ret_t   code;

  assign perr = (^opa) || (^opb);

  assign trap_en[EXC_INV] = fpcsr[CSR_INV_EN];
  assign trap_en[EXC_DEN] = fpcsr[CSR_DEN_EN];
  assign trap = |(raised & trap_en);

  // a parity error hides any raised exception
  always_comb begin
    if (perr)
      code = 4'b0001;
    else
      code = {raised, trap, 1'b0};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ret    <= '0;
      ret_en <= 1'b0;
    end else if (valid) begin
      ret    <= code;
      ret_en <= 1'b1;
    end else begin
      ret    <= '0;
      ret_en <= 1'b0;
    end
  end

endmodule

// File: fpu_result_stage.sv
// logic op, result select, parity generation and output registers
`timescale 1ns/1ps

module fpu_result_stage import fpu_op_pkg::*, fpu_data_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       valid,
  input  op_t        op_q,
  input  logic       is_cmp,
  input  bus_word_t  opa,
  input  bus_word_t  opb,
  input  cmp_flags_t flags_in,
  output logic       res_valid,
  output bus_word_t  res_bus,
  output cmp_flags_t flags
);

  data_t da;
  data_t db;
  data_t logic_res;
  data_t res_data;

  assign da = opa[DATA_W-1:0];
  assign db = opb[DATA_W-1:0];

  always_comb begin
    case (op_q)
      OP_OR:   logic_res = da | db;
      OP_XOR:  logic_res = da ^ db;
      OP_ANDN: logic_res = da & ~db;
      default: logic_res = da & db;
    endcase
  end

  // compares only report flags
  assign res_data = is_cmp ? '0 : logic_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      res_bus   <= '0;
      flags     <= '0;
    end else if (valid) begin
      res_valid <= 1'b1;
      // even parity over the full word
      res_bus   <= {^res_data, res_data};
      flags     <= flags_in;
    end else begin
      res_valid <= 1'b0;
      res_bus   <= '0;
      flags     <= '0;
    end
  end

endmodule

// File: fp_compare.sv
// double compare with eq/lt/gt/unord flags and invalid/denormal raise
`timescale 1ns/1ps

module fp_compare import fpu_data_pkg::*; (
  input  bus_word_t  opa,
  input  bus_word_t  opb,
  input  logic       is_cmp,
  input  logic       ordered,
  output cmp_flags_t flags,
  output excpt_t     raised
);

  data_t             da;
  data_t             db;
  logic              sign_a;
  logic              sign_b;
  logic [EXP_W-1:0]  exp_a;
  logic [EXP_W-1:0]  exp_b;
  logic [MANT_W-1:0] mant_a;
  logic [MANT_W-1:0] mant_b;
  logic              nan_a;
  logic              nan_b;
  logic              snan_a;
  logic              snan_b;
  logic              den_a;
  logic              den_b;
  logic              mag_lt;
  logic              mag_eq;
  logic              zero_both;
  logic              is_eq;
  logic              is_lt;

  assign da = opa[DATA_W-1:0];
  assign db = opb[DATA_W-1:0];

  assign sign_a = da[DATA_W-1];
  assign sign_b = db[DATA_W-1];
  assign exp_a  = da[DATA_W-2 -: EXP_W];
  assign exp_b  = db[DATA_W-2 -: EXP_W];
  assign mant_a = da[MANT_W-1:0];
  assign mant_b = db[MANT_W-1:0];

  assign nan_a  = (&exp_a) && (|mant_a);
  assign nan_b  = (&exp_b) && (|mant_b);
  // quiet bit clear means signalling
  assign snan_a = nan_a && !mant_a[MANT_W-1];
  assign snan_b = nan_b && !mant_b[MANT_W-1];
  assign den_a  = (exp_a == '0) && (|mant_a);
  assign den_b  = (exp_b == '0) && (|mant_b);

  // magnitude only, sign bit dropped
  assign mag_lt    = da[DATA_W-2:0] < db[DATA_W-2:0];
  assign mag_eq    = da[DATA_W-2:0] == db[DATA_W-2:0];
  assign zero_both = (da[DATA_W-2:0] == '0) && (db[DATA_W-2:0] == '0);

  always_comb begin
    is_eq = 1'b0;
    is_lt = 1'b0;
    if (zero_both || ((sign_a == sign_b) && mag_eq))
      is_eq = 1'b1;
    else if (sign_a != sign_b)
      is_lt = sign_a;
    else
      // negative values order the other way round
      is_lt = sign_a ? !mag_lt : mag_lt;
  end

  always_comb begin
    flags  = '0;
    raised = '0;
    if (is_cmp) begin
      if (nan_a || nan_b) begin
        flags[FLG_UNORD] = 1'b1;
      end else begin
        flags[FLG_EQ] = is_eq;
        flags[FLG_LT] = is_lt;
        flags[FLG_GT] = !is_eq && !is_lt;
      end
      raised[EXC_INV] = ordered ? (nan_a || nan_b) : (snan_a || snan_b);
      raised[EXC_DEN] = den_a || den_b;
    end
  end

endmodule

// File: fpu_op_decode.sv
// registered opcode decode into logic-select and compare controls
`timescale 1ns/1ps

module fpu_op_decode import fpu_op_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic en,
  input  op_t  op,
  output op_t  op_q,
  output logic is_cmp,
  output logic ordered,
  output logic valid
);

  op_t  op_dec;
  logic cmp_dec;
  logic ord_dec;

  // undefined codes fall back to and
  always_comb begin
    op_dec  = OP_AND;
    cmp_dec = 1'b0;
    ord_dec = 1'b0;
    case (op)
      OP_OR:   op_dec = OP_OR;
      OP_XOR:  op_dec = OP_XOR;
      OP_ANDN: op_dec = OP_ANDN;
      OP_CMP_ORD: begin
        op_dec  = OP_CMP_ORD;
        cmp_dec = 1'b1;
        ord_dec = 1'b1;
      end
      OP_CMP_UNORD: begin
        op_dec  = OP_CMP_UNORD;
        cmp_dec = 1'b1;
      end
      default: op_dec = OP_AND;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      op_q    <= OP_AND;
      is_cmp  <= 1'b0;
      ordered <= 1'b0;
      valid   <= 1'b0;
    end else begin
      valid <= en;
      if (en) begin
        op_q    <= op_dec;
        is_cmp  <= cmp_dec;
        ordered <= ord_dec;
      end else begin
        // keep the comparator quiet between ops
        is_cmp <= 1'b0;
      end
    end
  end

endmodule

// File: operand_bypass.sv
// operand source select between dispatch data and result buses,
// with a one-cycle-old copy of bus 0
`timescale 1ns/1ps

module operand_bypass import fpu_op_pkg::*, fpu_data_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      en,
  input  fwd_t      fwd_a,
  input  fwd_t      fwd_b,
  input  bus_word_t a,
  input  bus_word_t b,
  input  bus_word_t bus0,
  input  bus_word_t bus1,
  output bus_word_t opa,
  output bus_word_t opb,
  output logic      valid
);

  bus_word_t bus0_old;

  function automatic bus_word_t pick(input fwd_t sel, input bus_word_t disp,
                                     input bus_word_t b0, input bus_word_t b1,
                                     input bus_word_t b0_old);
    case (sel)
      FWD_BUS0:     pick = b0;
      FWD_BUS1:     pick = b1;
      FWD_BUS0_OLD: pick = b0_old;
      default:      pick = disp;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      bus0_old <= '0;
      valid    <= 1'b0;
    end else begin
      bus0_old <= bus0;
      valid    <= en;
    end
  end

  // parity bit travels with the data
  always_ff @(posedge clk) begin
    if (en) begin
      opa <= pick(fwd_a, a, bus0, bus1, bus0_old);
      opb <= pick(fwd_b, b, bus0, bus1, bus0_old);
    end
  end

endmodule

// File: fpu_data_pkg.sv
// double, bus word, compare flag, exception and completion-code types
package fpu_data_pkg;

  localparam int DATA_W = 64;
  localparam int EXP_W  = 11;
  localparam int MANT_W = 52;

  typedef logic [DATA_W-1:0] data_t;

  // data with parity on top, xor of the whole word is zero when good
  typedef logic [DATA_W:0] bus_word_t;

  typedef logic [3:0] cmp_flags_t;
  localparam int FLG_EQ    = 0;
  localparam int FLG_LT    = 1;
  localparam int FLG_GT    = 2;
  localparam int FLG_UNORD = 3;

  typedef logic [1:0] excpt_t;
  localparam int EXC_INV = 0;
  localparam int EXC_DEN = 1;

  // {raised[1:0], trap, parity error}
  typedef logic [3:0] ret_t;

endpackage

// File: fpu_op_pkg.sv
// opcode and operand-source enums, control register type
// and trap-enable bit positions
package fpu_op_pkg;

  // operations handled by the logic/compare port
  typedef enum logic [2:0] {
    OP_AND       = 3'd0,
    OP_OR        = 3'd1,
    OP_XOR       = 3'd2,
    OP_ANDN      = 3'd3,
    OP_CMP_ORD   = 3'd4,
    OP_CMP_UNORD = 3'd5
  } op_t;

  // where an operand comes from
  typedef enum logic [1:0] {
    FWD_NONE     = 2'd0,
    FWD_BUS0     = 2'd1,
    FWD_BUS1     = 2'd2,
    // bus 0 one cycle back
    FWD_BUS0_OLD = 2'd3
  } fwd_t;

  typedef logic [31:0] fpcsr_t;

  // trap enables in fpcsr
  localparam int CSR_INV_EN = 0;
  localparam int CSR_DEN_EN = 1;

endpackage
